// File: Bender.yml
package:
  name: mips_core

sources:
  - files:
      - hw/cpuPkg.sv
      - hw/cpuIf.sv
      - hw/fetchStage.sv
      - hw/decodeStage.sv
      - hw/regFile.sv
      - hw/executeStage.sv
      - hw/hazardUnit.sv
      - hw/mipsCore.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tbCore.sv

// File: hw/cpuIf.sv
`timescale 1ns/1ps
`default_nettype none

// fetch to decode register
interface fetchIf import cpuPkg::*; ();
    logic  valid;
    word_t pc;
    word_t pcPlus4;
    word_t instr;

    modport producer (output valid, pc, pcPlus4, instr);
    modport consumer (input valid, pc, pcPlus4, instr);
endinterface

// decode to execute register
interface issueIf import cpuPkg::*; ();
    logic   valid;
    word_t  pc;
    aluOp_t aluOp;
    word_t  opA;
    word_t  opB;
    word_t  storeData;
    regNum_t dest;
    logic   regWrite;
    logic   memRead;
    logic   memWrite;
    logic   isBranch;
    logic   branchNe;
    word_t  branchTarget;

    modport producer (output valid, pc, aluOp, opA, opB, storeData, dest, regWrite,
                      memRead, memWrite, isBranch, branchNe, branchTarget);
    modport consumer (input valid, pc, aluOp, opA, opB, storeData, dest, regWrite,
                      memRead, memWrite, isBranch, branchNe, branchTarget);
    modport monitor (input valid, regWrite, memRead, dest);
endinterface

// memory stage result and writeback commit
interface wbIf import cpuPkg::*; ();
    logic    memValid;
    logic    memRegWrite;
    regNum_t memDest;
    word_t   memResult;
    logic    wbValid;
    logic    wbRegWrite;
    regNum_t wbDest;
    word_t   wbData;
    word_t   wbPc;

    modport producer (output memValid, memRegWrite, memDest, memResult,
                      wbValid, wbRegWrite, wbDest, wbData, wbPc);
    modport reader (input memValid, memRegWrite, memDest, memResult,
                    wbValid, wbRegWrite, wbDest, wbData, wbPc);
endinterface

`default_nettype wire

// File: hw/cpuPkg.sv
`default_nettype none

package cpuPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regNum_t;

    // primary opcode in instr[31:26]
    typedef enum logic [5:0] {
        OpSpecial = 6'h00,
        OpJ       = 6'h02,
        OpBeq     = 6'h04,
        OpBne     = 6'h05,
        OpAddiu   = 6'h09,
        OpAndi    = 6'h0c,
        OpOri     = 6'h0d,
        OpLui     = 6'h0f,
        OpLw      = 6'h23,
        OpSw      = 6'h2b
    } opcode_t;

    // funct field of OpSpecial in instr[5:0]
    typedef enum logic [5:0] {
        FnSll  = 6'h00,
        FnAddu = 6'h21,
        FnSubu = 6'h23,
        FnAnd  = 6'h24,
        FnOr   = 6'h25,
        FnXor  = 6'h26,
        FnSlt  = 6'h2a
    } funct_t;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluSlt,
        AluSll,
        AluLui
    } aluOp_t;

    // operand source for decode in forwarding priority order
    typedef enum logic [1:0] {
        FwdReg,
        FwdExec,
        FwdMem,
        FwdWb
    } fwdSel_t;

    localparam word_t Nop = 32'h0000_0000; // sll $0, $0, 0

endpackage

`default_nettype wire

// File: hw/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage import cpuPkg::*; (
    input  logic     clk_i,
    input  logic     rstN_i,
    input  logic     stall_i,
    input  logic     flush_i,
    input  fwdSel_t  fwdA_i,
    input  fwdSel_t  fwdB_i,
    input  word_t    execResult_i,
    input  word_t    rdA_i,
    input  word_t    rdB_i,
    output regNum_t  rsNum_o,
    output regNum_t  rtNum_o,
    output logic     jump_o,
    output word_t    jumpPc_o,
    fetchIf.consumer fetch_i,
    wbIf.reader      wb_i,
    issueIf.producer issue_o
);

    word_t   instr;
    opcode_t opcode;
    funct_t  funct;
    word_t   immSext;
    word_t   imm;
    word_t   rsVal;
    word_t   rtVal;
    regNum_t dest;
    aluOp_t  aluOp;
    logic    useImm;
    logic    zeroExt;
    logic    isShift;
    logic    usesRs;
    logic    usesRt;
    logic    destRt;
    logic    regWrite;
    logic    memRead;
    logic    memWrite;
    logic    isBranch;
    logic    branchNe;
    logic    isJump;
    logic    known;
    logic    issueLive;

    function automatic word_t fwdMux(fwdSel_t sel, word_t regVal, word_t execVal,
                                     word_t memVal, word_t wbVal);
        case (sel)
            FwdExec: return execVal;
            FwdMem:  return memVal;
            FwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign instr   = fetch_i.valid ? fetch_i.instr : Nop; // empty slot decodes as nop
    assign opcode  = opcode_t'(instr[31:26]);
    assign funct   = funct_t'(instr[5:0]);
    assign immSext = {{16{instr[15]}}, instr[15:0]};
    assign imm     = zeroExt ? {16'h0000, instr[15:0]} : immSext;

    always_comb begin
        aluOp    = AluAdd;
        useImm   = 1'b0;
        zeroExt  = 1'b0;
        isShift  = 1'b0;
        usesRs   = 1'b1;
        usesRt   = 1'b0;
        destRt   = 1'b1;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        isBranch = 1'b0;
        branchNe = 1'b0;
        isJump   = 1'b0;
        known    = 1'b1;
        case (opcode)
            OpSpecial: begin
                usesRt   = 1'b1;
                destRt   = 1'b0;
                regWrite = 1'b1;
                case (funct)
                    FnSll: begin
                        aluOp   = AluSll;
                        isShift = 1'b1;
                        usesRs  = 1'b0;
                    end
                    FnAddu:  aluOp = AluAdd;
                    FnSubu:  aluOp = AluSub;
                    FnAnd:   aluOp = AluAnd;
                    FnOr:    aluOp = AluOr;
                    FnXor:   aluOp = AluXor;
                    FnSlt:   aluOp = AluSlt;
                    default: begin
                        regWrite = 1'b0;
                        known    = 1'b0;
                    end
                endcase
            end
            OpAddiu: begin
                useImm   = 1'b1;
                regWrite = 1'b1;
            end
            OpAndi, OpOri: begin
                aluOp    = (opcode == OpAndi) ? AluAnd : AluOr;
                useImm   = 1'b1;
                zeroExt  = 1'b1; // logical immediates are zero-extended
                regWrite = 1'b1;
            end
            OpLui: begin
                aluOp    = AluLui;
                useImm   = 1'b1;
                usesRs   = 1'b0;
                regWrite = 1'b1;
            end
            OpLw: begin
                useImm   = 1'b1;
                regWrite = 1'b1;
                memRead  = 1'b1;
            end
            OpSw: begin
                useImm   = 1'b1;
                usesRt   = 1'b1;
                memWrite = 1'b1;
            end
            OpBeq, OpBne: begin
                usesRt   = 1'b1;
                isBranch = 1'b1;
                branchNe = (opcode == OpBne);
            end
            OpJ: begin
                usesRs = 1'b0;
                isJump = 1'b1;
            end
            default: begin
                usesRs = 1'b0;
                known  = 1'b0;
            end
        endcase
    end

    // unused source fields read as $0 so they never forward or stall
    assign rsNum_o = usesRs ? instr[25:21] : '0;
    assign rtNum_o = usesRt ? instr[20:16] : '0;
    assign dest    = destRt ? instr[20:16] : instr[15:11];

    assign rsVal = fwdMux(fwdA_i, rdA_i, execResult_i, wb_i.memResult, wb_i.wbData);
    assign rtVal = fwdMux(fwdB_i, rdB_i, execResult_i, wb_i.memResult, wb_i.wbData);

    assign jump_o    = fetch_i.valid && isJump && !stall_i;
    assign jumpPc_o  = {fetch_i.pcPlus4[31:28], instr[25:0], 2'b00};
    assign issueLive = fetch_i.valid && known && !stall_i && !flush_i;

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            issue_o.valid    <= 1'b0;
            issue_o.regWrite <= 1'b0;
            issue_o.memRead  <= 1'b0;
            issue_o.memWrite <= 1'b0;
            issue_o.isBranch <= 1'b0;
        end else begin
            issue_o.valid    <= issueLive;
            issue_o.regWrite <= issueLive && regWrite && (dest != '0);
            issue_o.memRead  <= issueLive && memRead;
            issue_o.memWrite <= issueLive && memWrite;
            issue_o.isBranch <= issueLive && isBranch;
        end
    end

    always_ff @(posedge clk_i) begin
        issue_o.pc           <= fetch_i.pc;
        issue_o.aluOp        <= aluOp;
        issue_o.opA          <= isShift ? {27'd0, instr[10:6]} : rsVal; // shamt for sll
        issue_o.opB          <= useImm ? imm : rtVal;
        issue_o.storeData    <= rtVal;
        issue_o.dest         <= dest;
        issue_o.branchNe     <= branchNe;
        issue_o.branchTarget <= fetch_i.pcPlus4 + {immSext[29:0], 2'b00};
    end

    knownOpcode: assert property (@(posedge clk_i) disable iff (!rstN_i)
        fetch_i.valid |-> known)
        else $error("unknown instruction %h at %h", instr, fetch_i.pc);

endmodule

`default_nettype wire

// File: hw/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage import cpuPkg::*; (
    input  logic     clk_i,
    input  logic     rstN_i,
    input  word_t    dmemRdata_i,
    output word_t    execResult_o,
    output logic     redirect_o,
    output word_t    redirectPc_o,
    output logic     dmemEn_o,
    output logic     dmemWe_o,
    output word_t    dmemAddr_o,
    output word_t    dmemWdata_o,
    issueIf.consumer issue_i,
    wbIf.producer    wb_o
);

    word_t aluOut;
    logic  memReadM;
    word_t aluM;
    word_t pcM;

    always_comb begin
        case (issue_i.aluOp)
            AluSub:  aluOut = issue_i.opA - issue_i.opB;
            AluAnd:  aluOut = issue_i.opA & issue_i.opB;
            AluOr:   aluOut = issue_i.opA | issue_i.opB;
            AluXor:  aluOut = issue_i.opA ^ issue_i.opB;
            AluSlt:  aluOut = {31'd0, $signed(issue_i.opA) < $signed(issue_i.opB)};
            AluSll:  aluOut = issue_i.opB << issue_i.opA[4:0];
            AluLui:  aluOut = {issue_i.opB[15:0], 16'h0000};
            default: aluOut = issue_i.opA + issue_i.opB; // also load/store address
        endcase
    end

    assign execResult_o = aluOut;

    // predicted not taken, so only a taken branch redirects
    assign redirect_o   = issue_i.isBranch && ((issue_i.opA == issue_i.opB) ^ issue_i.branchNe);
    assign redirectPc_o = issue_i.branchTarget;

    assign dmemEn_o    = issue_i.memRead || issue_i.memWrite;
    assign dmemWe_o    = issue_i.memWrite;
    assign dmemAddr_o  = aluOut;
    assign dmemWdata_o = issue_i.storeData;

    // load data shows up while the load sits in memory
    assign wb_o.memResult = memReadM ? dmemRdata_i : aluM;

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            wb_o.memValid    <= 1'b0;
            wb_o.memRegWrite <= 1'b0;
            memReadM         <= 1'b0;
            wb_o.wbValid     <= 1'b0;
            wb_o.wbRegWrite  <= 1'b0;
        end else begin
            wb_o.memValid    <= issue_i.valid;
            wb_o.memRegWrite <= issue_i.regWrite;
            memReadM         <= issue_i.memRead;
            wb_o.wbValid     <= wb_o.memValid;
            wb_o.wbRegWrite  <= wb_o.memRegWrite;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_o.memDest <= issue_i.dest;
        aluM         <= aluOut;
        pcM          <= issue_i.pc;
        wb_o.wbDest  <= wb_o.memDest;
        wb_o.wbData  <= wb_o.memResult;
        wb_o.wbPc    <= pcM;
    end

    memAligned: assert property (@(posedge clk_i) disable iff (!rstN_i)
        dmemEn_o |-> (dmemAddr_o[1:0] == 2'b00))
        else $error("misaligned data address %h at pc %h", dmemAddr_o, issue_i.pc);

    // a store never arrives flagged as a load too
    weNeedsEn: assert property (@(posedge clk_i) disable iff (!rstN_i)
        dmemWe_o |-> (dmemEn_o && !issue_i.memRead))
        else $error("data write without enable or flagged as a read");

endmodule

`default_nettype wire

// File: hw/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage import cpuPkg::*; #(
    parameter word_t ResetPc = 32'hbfc0_0000
) (
    input  logic     clk_i,
    input  logic     rstN_i,
    input  logic     stall_i,
    input  logic     flush_i,
    input  logic     redirect_i,
    input  word_t    redirectPc_i,
    input  logic     jump_i,
    input  word_t    jumpPc_i,
    input  word_t    instr_i,
    output word_t    pc_o,
    fetchIf.producer fetch_o
);

    word_t pcReg;
    word_t pcPlus4;
    word_t pcNext;

    assign pcPlus4 = pcReg + 32'd4;
    assign pc_o    = pcReg; // imem reads this combinationally

    // taken branch beats jump
    always_comb begin
        if (redirect_i) begin
            pcNext = redirectPc_i;
        end else if (jump_i) begin
            pcNext = jumpPc_i;
        end else begin
            pcNext = pcPlus4;
        end
    end

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            pcReg         <= ResetPc;
            fetch_o.valid <= 1'b0;
        end else begin
            if (!stall_i) begin
                pcReg <= pcNext;
            end
            if (flush_i) begin
                fetch_o.valid <= 1'b0; // wrong-path fetch
            end else if (!stall_i) begin
                fetch_o.valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            fetch_o.pc      <= pcReg;
            fetch_o.pcPlus4 <= pcPlus4;
            fetch_o.instr   <= instr_i;
        end
    end

    pcAligned: assert property (@(posedge clk_i) disable iff (!rstN_i) pc_o[1:0] == 2'b00)
        else $error("misaligned pc %h", pc_o);

endmodule

`default_nettype wire

// File: hw/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import cpuPkg::*; (
    input  regNum_t  rsNum_i,
    input  regNum_t  rtNum_i,
    input  logic     redirect_i,
    input  logic     jump_i,
    output logic     stallF_o,
    output logic     stallD_o,
    output logic     flushD_o,
    output logic     flushE_o,
    output fwdSel_t  fwdA_o,
    output fwdSel_t  fwdB_o,
    issueIf.monitor  issue_i,
    wbIf.reader      wb_i
);

    logic loadUse;
    logic exWr;
    logic memWr;
    logic wbWr;

    // nearest producer wins
    function automatic fwdSel_t pickFwd(regNum_t src, regNum_t exDest, regNum_t memDest,
                                        regNum_t wbDest, logic exHit, logic memHit,
                                        logic wbHit);
        if (src == '0) return FwdReg;
        if (exHit && (exDest == src)) return FwdExec;
        if (memHit && (memDest == src)) return FwdMem;
        if (wbHit && (wbDest == src)) return FwdWb;
        return FwdReg;
    endfunction

    assign exWr  = issue_i.valid && issue_i.regWrite;
    assign memWr = wb_i.memValid && wb_i.memRegWrite;
    assign wbWr  = wb_i.wbValid && wb_i.wbRegWrite;

    assign fwdA_o = pickFwd(rsNum_i, issue_i.dest, wb_i.memDest, wb_i.wbDest, exWr, memWr, wbWr);
    assign fwdB_o = pickFwd(rtNum_i, issue_i.dest, wb_i.memDest, wb_i.wbDest, exWr, memWr, wbWr);

    // load data is not ready until memory
    assign loadUse = issue_i.valid && issue_i.memRead && (issue_i.dest != '0)
                     && ((issue_i.dest == rsNum_i) || (issue_i.dest == rtNum_i));

    assign stallF_o = loadUse && !redirect_i;
    assign stallD_o = loadUse && !redirect_i;
    assign flushD_o = redirect_i || jump_i;
    assign flushE_o = redirect_i;

endmodule

`default_nettype wire

// File: hw/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore import cpuPkg::*; #(
    parameter word_t ResetPc = 32'hbfc0_0000
) (
    input  logic    clk_i,
    input  logic    rstN_i,
    output word_t   imemAddr_o,
    input  word_t   imemData_i,
    output logic    dmemEn_o,
    output logic    dmemWe_o,
    output word_t   dmemAddr_o,
    output word_t   dmemWdata_o,
    input  word_t   dmemRdata_i,
    output word_t   wbPc_o,
    output logic    wbWen_o,
    output regNum_t wbNum_o,
    output word_t   wbData_o
);

    fetchIf fetchBus ();
    issueIf issueBus ();
    wbIf    wbBus ();

    logic    redirect;
    word_t   redirectPc;
    logic    jump;
    word_t   jumpPc;
    logic    stallF;
    logic    stallD;
    logic    flushD;
    logic    flushE;
    fwdSel_t fwdA;
    fwdSel_t fwdB;
    word_t   execResult;
    regNum_t rsNum;
    regNum_t rtNum;
    word_t   rdA;
    word_t   rdB;

    // debug trace of each commit
    assign wbPc_o   = wbBus.wbPc;
    assign wbWen_o  = wbBus.wbValid && wbBus.wbRegWrite;
    assign wbNum_o  = wbBus.wbDest;
    assign wbData_o = wbBus.wbData;

    fetchStage #(
        .ResetPc(ResetPc)
    ) i_fetchStage (
        .clk_i        (clk_i),
        .rstN_i       (rstN_i),
        .stall_i      (stallF),
        .flush_i      (flushD),
        .redirect_i   (redirect),
        .redirectPc_i (redirectPc),
        .jump_i       (jump),
        .jumpPc_i     (jumpPc),
        .instr_i      (imemData_i),
        .pc_o         (imemAddr_o),
        .fetch_o      (fetchBus.producer)
    );

    decodeStage i_decodeStage (
        .clk_i        (clk_i),
        .rstN_i       (rstN_i),
        .stall_i      (stallD),
        .flush_i      (flushE),
        .fwdA_i       (fwdA),
        .fwdB_i       (fwdB),
        .execResult_i (execResult),
        .rdA_i        (rdA),
        .rdB_i        (rdB),
        .rsNum_o      (rsNum),
        .rtNum_o      (rtNum),
        .jump_o       (jump),
        .jumpPc_o     (jumpPc),
        .fetch_i      (fetchBus.consumer),
        .wb_i         (wbBus.reader),
        .issue_o      (issueBus.producer)
    );

    regFile i_regFile (
        .clk_i   (clk_i),
        .rstN_i  (rstN_i),
        .rsNum_i (rsNum),
        .rtNum_i (rtNum),
        .rdA_o   (rdA),
        .rdB_o   (rdB),
        .wb_i    (wbBus.reader)
    );

    executeStage i_executeStage (
        .clk_i        (clk_i),
        .rstN_i       (rstN_i),
        .dmemRdata_i  (dmemRdata_i),
        .execResult_o (execResult),
        .redirect_o   (redirect),
        .redirectPc_o (redirectPc),
        .dmemEn_o     (dmemEn_o),
        .dmemWe_o     (dmemWe_o),
        .dmemAddr_o   (dmemAddr_o),
        .dmemWdata_o  (dmemWdata_o),
        .issue_i      (issueBus.consumer),
        .wb_o         (wbBus.producer)
    );

    hazardUnit i_hazardUnit (
        .rsNum_i    (rsNum),
        .rtNum_i    (rtNum),
        .redirect_i (redirect),
        .jump_i     (jump),
        .stallF_o   (stallF),
        .stallD_o   (stallD),
        .flushD_o   (flushD),
        .flushE_o   (flushE),
        .fwdA_o     (fwdA),
        .fwdB_o     (fwdB),
        .issue_i    (issueBus.monitor),
        .wb_i       (wbBus.reader)
    );

endmodule

`default_nettype wire

// File: hw/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import cpuPkg::*; (
    input  logic    clk_i,
    input  logic    rstN_i,
    input  regNum_t rsNum_i,
    input  regNum_t rtNum_i,
    output word_t   rdA_o,
    output word_t   rdB_o,
    wbIf.reader     wb_i
);

    word_t regs [1:31]; // $0 has no storage

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.wbValid && wb_i.wbRegWrite && (wb_i.wbDest != '0)) begin
            regs[wb_i.wbDest] <= wb_i.wbData;
        end
    end

    // same-cycle writeback is covered by forwarding in decode
    assign rdA_o = (rsNum_i == '0) ? '0 : regs[rsNum_i];
    assign rdB_o = (rtNum_i == '0) ? '0 : regs[rtNum_i];

endmodule

`default_nettype wire

// File: sim.f
+incdir+sim
hw/cpuPkg.sv
hw/cpuIf.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/regFile.sv
hw/executeStage.sv
hw/hazardUnit.sv
hw/mipsCore.sv
sim/tbCore.sv

// File: sim/tbProgram.svh
// one row per test holding each instruction and the commit it should produce
// expReg of 0 means the instruction must not commit (store, branch, jump, wrong path)
localparam int NumTests = 5;
localparam int MaxLen   = 16;

string   testName [NumTests];
word_t   code     [NumTests][MaxLen];
regNum_t expReg   [NumTests][MaxLen];
word_t   expVal   [NumTests][MaxLen];
int      progLen  [NumTests];

function automatic word_t rType(int rs, int rt, int rd, int sh, logic [5:0] fn);
    return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
endfunction

function automatic word_t iType(logic [5:0] op, int rs, int rt, logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
endfunction

// absolute jump to word k of the program
function automatic word_t jType(int k);
    word_t target;
    target = (TbResetPc >> 2) + k;
    return {6'h02, target[25:0]};
endfunction

task automatic put(int t, word_t w, int r, word_t v);
    code[t][progLen[t]]   = w;
    expReg[t][progLen[t]] = regNum_t'(r);
    expVal[t][progLen[t]] = v;
    progLen[t]++;
endtask

task automatic buildDirected();
    for (int t = 0; t < NumTests; t++) begin
        progLen[t] = 0;
    end
    testName[0] = "aluImm";
    put(0, iType(6'h09, 0, 1, 16'h0005), 1, 32'h0000_0005);
    put(0, iType(6'h09, 0, 2, 16'hfffd), 2, 32'hffff_fffd);
    put(0, iType(6'h0d, 0, 3, 16'hf0f0), 3, 32'h0000_f0f0);
    put(0, iType(6'h0c, 2, 4, 16'h00ff), 4, 32'h0000_00fd);
    put(0, iType(6'h0f, 0, 5, 16'h1234), 5, 32'h1234_0000);
    put(0, rType(1, 3, 6, 0, 6'h21), 6, 32'h0000_f0f5);
    put(0, rType(1, 2, 7, 0, 6'h23), 7, 32'h0000_0008);
    put(0, rType(2, 3, 8, 0, 6'h24), 8, 32'h0000_f0f0);
    put(0, rType(1, 5, 9, 0, 6'h25), 9, 32'h1234_0005);
    put(0, rType(3, 2, 10, 0, 6'h26), 10, 32'hffff_0f0d);
    put(0, rType(2, 1, 11, 0, 6'h2a), 11, 32'h0000_0001);
    put(0, rType(0, 1, 12, 4, 6'h00), 12, 32'h0000_0050);
    put(0, rType(1, 2, 13, 0, 6'h2a), 13, 32'h0000_0000);

    testName[1] = "fwdChain"; // exec, mem and wb distances
    put(1, iType(6'h09, 0, 1, 16'h0001), 1, 32'h0000_0001);
    put(1, rType(1, 1, 2, 0, 6'h21), 2, 32'h0000_0002);
    put(1, rType(2, 1, 3, 0, 6'h21), 3, 32'h0000_0003);
    put(1, rType(3, 1, 4, 0, 6'h21), 4, 32'h0000_0004);
    put(1, rType(4, 2, 5, 0, 6'h21), 5, 32'h0000_0006);
    put(1, rType(5, 1, 6, 0, 6'h26), 6, 32'h0000_0007);
    put(1, iType(6'h0d, 6, 1, 16'h0010), 1, 32'h0000_0017);
    put(1, rType(1, 6, 7, 0, 6'h21), 7, 32'h0000_001e);

    testName[2] = "memory";
    put(2, iType(6'h09, 0, 1, 16'h1234), 1, 32'h0000_1234);
    put(2, iType(6'h0f, 0, 2, 16'habcd), 2, 32'habcd_0000);
    put(2, rType(2, 1, 2, 0, 6'h25), 2, 32'habcd_1234);
    put(2, iType(6'h2b, 0, 2, 16'h0040), 0, '0);
    put(2, iType(6'h23, 0, 3, 16'h0040), 3, 32'habcd_1234);
    put(2, rType(3, 1, 4, 0, 6'h21), 4, 32'habcd_2468); // load-use
    put(2, iType(6'h2b, 0, 4, 16'h0044), 0, '0);
    put(2, iType(6'h23, 0, 5, 16'h0044), 5, 32'habcd_2468);
    put(2, rType(5, 2, 6, 0, 6'h26), 6, 32'h0000_365c);

    testName[3] = "control";
    put(3, iType(6'h09, 0, 1, 16'h0001), 1, 32'h0000_0001);
    put(3, iType(6'h04, 1, 0, 16'h0005), 0, '0); // not taken
    put(3, iType(6'h09, 0, 2, 16'h0002), 2, 32'h0000_0002);
    put(3, iType(6'h05, 1, 0, 16'h0002), 0, '0); // taken to word 6
    put(3, iType(6'h09, 0, 3, 16'h0033), 0, '0);
    put(3, iType(6'h09, 0, 4, 16'h0044), 0, '0);
    put(3, iType(6'h09, 0, 5, 16'h0005), 5, 32'h0000_0005);
    put(3, jType(10), 0, '0);
    put(3, iType(6'h09, 0, 6, 16'h0066), 0, '0);
    put(3, iType(6'h09, 0, 7, 16'h0077), 0, '0);
    put(3, iType(6'h04, 5, 5, 16'h0001), 0, '0); // taken to word 12
    put(3, iType(6'h09, 0, 8, 16'h0088), 0, '0);
    put(3, iType(6'h09, 5, 9, 16'h0004), 9, 32'h0000_0009);
endtask

// File: sim/tbCore.sv
`timescale 1ns/1ps
`default_nettype none

module tbCore import cpuPkg::*; ();

    localparam word_t TbResetPc = 32'hbfc0_0000;

    logic    clk_i;
    logic    rstN_i;
    word_t   imemAddr_o;
    word_t   imemData_i;
    logic    dmemEn_o;
    logic    dmemWe_o;
    word_t   dmemAddr_o;
    word_t   dmemWdata_o;
    word_t   dmemRdata_i;
    word_t   wbPc_o;
    logic    wbWen_o;
    regNum_t wbNum_o;
    word_t   wbData_o;

    word_t imem [64];
    word_t dmem [256];
    word_t rng = 32'h3802cf27;
    int    cycles = 0;
    int    limit = 1000000; // replaced once the tables exist

    `include "tbProgram.svh"

    mipsCore #(
        .ResetPc(TbResetPc)
    ) i_dut (
        .clk_i       (clk_i),
        .rstN_i      (rstN_i),
        .imemAddr_o  (imemAddr_o),
        .imemData_i  (imemData_i),
        .dmemEn_o    (dmemEn_o),
        .dmemWe_o    (dmemWe_o),
        .dmemAddr_o  (dmemAddr_o),
        .dmemWdata_o (dmemWdata_o),
        .dmemRdata_i (dmemRdata_i),
        .wbPc_o      (wbPc_o),
        .wbWen_o     (wbWen_o),
        .wbNum_o     (wbNum_o),
        .wbData_o    (wbData_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // instruction memory answers in the same cycle
    assign imemData_i = imem[6'((imemAddr_o - TbResetPc) >> 2)];

    // data memory returns read data one cycle later
    always @(posedge clk_i) begin : dmemModel
        word_t rd;
        rd = dmem[dmemAddr_o[9:2]];
        if (dmemEn_o && dmemWe_o) begin
            dmem[dmemAddr_o[9:2]] = dmemWdata_o;
        end
        #10 dmemRdata_i <= rd;
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: no progress after %0d cycles", cycles);
            $display("sim failed");
            $fatal(1);
        end
    end

    function automatic word_t xorshift(word_t x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // random addiu, ori, addu, xor chains over $0..$7 with a golden model
    task automatic buildRandom(int t);
        word_t gold [8];
        int    rd;
        int    rs;
        int    rt;
        logic [15:0] imm;
        word_t v;
        word_t w;
        for (int i = 0; i < 8; i++) begin
            gold[i] = '0;
        end
        testName[t] = "randomChain";
        for (int i = 0; i < MaxLen; i++) begin
            rng = xorshift(rng);
            rd  = 1 + (rng % 7);
            rs  = (rng >> 8) % 8;
            rt  = (rng >> 12) % 8;
            imm = rng[31:16];
            case (rng[5:4])
                2'd0: begin
                    w = iType(6'h09, rs, rd, imm);
                    v = gold[rs] + {{16{imm[15]}}, imm};
                end
                2'd1: begin
                    w = iType(6'h0d, rs, rd, imm);
                    v = gold[rs] | {16'h0000, imm};
                end
                2'd2: begin
                    w = rType(rs, rt, rd, 0, 6'h21);
                    v = gold[rs] + gold[rt];
                end
                default: begin
                    w = rType(rs, rt, rd, 0, 6'h26);
                    v = gold[rs] ^ gold[rt];
                end
            endcase
            gold[rd] = v;
            put(t, w, rd, v);
        end
    endtask

    task automatic checkWord(string name, string what, word_t expected, word_t actual);
        assert (expected === actual) else begin
            $display("FAILED %s %s expected %h actual %h", name, what, expected, actual);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic checkTrue(string name, logic cond, string msg);
        assert (cond === 1'b1) else begin
            $display("error in %s: %s", name, msg);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic runTest(int t);
        int pending [$];
        int idx;
        int idle;
        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < progLen[t]) ? code[t][i] : Nop;
        end
        for (int a = 0; a < 256; a++) begin
            dmem[a] = word_t'(a) * 32'h9e37_79b1 ^ 32'h5a5a_0000;
        end
        for (int i = 0; i < progLen[t]; i++) begin
            if (expReg[t][i] != '0) begin
                pending.push_back(i);
            end
        end

        @(posedge clk_i);
        #10 rstN_i = 1'b0;
        repeat (4) begin
            @(negedge clk_i);
            checkTrue(testName[t], !wbWen_o, "commit seen during reset");
            checkTrue(testName[t], !dmemEn_o && !dmemWe_o, "data access during reset");
            checkWord(testName[t], "reset pc", TbResetPc, imemAddr_o);
        end
        @(posedge clk_i);
        #10 rstN_i = 1'b1;

        idle = 0;
        while (pending.size() > 0 || idle < 12) begin
            @(negedge clk_i);
            if (wbWen_o) begin
                checkTrue(testName[t], pending.size() > 0, "commit after the last expected one");
                idx = pending.pop_front();
                checkWord(testName[t], "pc", TbResetPc + 4 * idx, wbPc_o);
                checkWord(testName[t], "reg", word_t'(expReg[t][idx]), word_t'(wbNum_o));
                checkWord(testName[t], "data", expVal[t][idx], wbData_o);
            end else if (pending.size() == 0) begin
                idle++; // draining where nothing more may commit
            end
        end
    endtask

    initial begin : main
        int total;
        rstN_i      = 1'b0;
        dmemRdata_i = '0;
        buildDirected();
        buildRandom(4);
        total = 0;
        for (int t = 0; t < NumTests; t++) begin
            total += progLen[t] * 4 + 20;
        end
        limit = total;
        for (int t = 0; t < NumTests; t++) begin
            runTest(t);
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire
